//--- hdl/cache_pkg.sv
package cache_pkg;

  // the CPU sees memory as one 32-bit word per address
  typedef logic [31:0] word_t;
  typedef logic [29:0] word_addr_t;

  // an all-zero mask marks a read
  typedef logic [3:0] byte_mask_t;

  typedef logic [1:0] word_sel_t;

  localparam int WORDS_PER_LINE = 4;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_WRITEBACK,
    ST_FETCH,
    ST_FILL
  } ctrl_state_t;

endpackage

//--- hdl/mem_pkg.sv
package mem_pkg;

  // one address per 128-bit line
  typedef logic [27:0] line_addr_t;

  // word 0 sits in the low 32 bits
  typedef logic [127:0] line_t;

endpackage

//--- hdl/mem_req_if.sv
`timescale 1ns/10ps

interface mem_req_if;
  import mem_pkg::*;

  logic       valid;
  logic       write;
  line_addr_t addr;
  line_t      data;
  // one pulse per entry that leaves the queue toward memory
  logic       credit;

  modport producer (
    output valid,
    output write,
    output addr,
    output data,
    input  credit
  );

  modport buffer (
    input  valid,
    input  write,
    input  addr,
    input  data,
    output credit
  );

endinterface

//--- hdl/cache_meta.sv
`timescale 1ns/10ps

module cache_meta #(
  parameter int LINES = 64,
  localparam int INDEX_W = $clog2(LINES),
  localparam int TAG_W = $bits(cache_pkg::word_addr_t) -
                         $clog2(cache_pkg::WORDS_PER_LINE) - INDEX_W
) (
  input  logic               clk,
  input  logic               reset,
  input  logic [INDEX_W-1:0] rd_index,
  input  logic               wr_en,
  input  logic [INDEX_W-1:0] wr_index,
  input  logic               wr_valid,
  input  logic               wr_dirty,
  input  logic [TAG_W-1:0]   wr_tag,
  output logic               rd_valid,
  output logic               rd_dirty,
  output logic [TAG_W-1:0]   rd_tag
);

  logic [LINES-1:0] valid_q;
  logic             dirty_q [LINES];
  logic [TAG_W-1:0] tag_q [LINES];

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q  <= '0;
      rd_valid <= 1'b0;
    end else begin
      if (wr_en) begin
        valid_q[wr_index] <= wr_valid;
      end
      rd_valid <= valid_q[rd_index];
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      dirty_q[wr_index] <= wr_dirty;
      tag_q[wr_index]   <= wr_tag;
    end
    rd_dirty <= dirty_q[rd_index];
    rd_tag   <= tag_q[rd_index];
  end

endmodule

//--- hdl/cache_data.sv
`timescale 1ns/10ps

module cache_data #(
  parameter int LINES = 64,
  localparam int INDEX_W = $clog2(LINES)
) (
  input  logic                  clk,
  input  logic [INDEX_W-1:0]    rd_index,
  output mem_pkg::line_t        rd_line,
  input  logic [INDEX_W-1:0]    wr_index,
  input  logic                  fill_en,
  input  mem_pkg::line_t        fill_line,
  input  logic                  word_en,
  input  cache_pkg::word_sel_t  word_sel,
  input  cache_pkg::word_t      word_data,
  input  cache_pkg::byte_mask_t word_mask
);
  import cache_pkg::*;
  import mem_pkg::*;

  localparam int WORD_W = $bits(word_t);

  line_t lines [LINES];

  always_ff @(posedge clk) begin
    if (fill_en) begin
      lines[wr_index] <= fill_line;
    end else if (word_en) begin
      // only the enabled bytes of the selected word change
      for (int b = 0; b < $bits(byte_mask_t); b++) begin
        if (word_mask[b]) begin
          lines[wr_index][int'(word_sel) * WORD_W + b * 8 +: 8] <= word_data[b * 8 +: 8];
        end
      end
    end
    rd_line <= lines[rd_index];
  end

endmodule

//--- hdl/cache_ctrl.sv
`timescale 1ns/10ps

module cache_ctrl #(
  parameter int LINES = 64,
  parameter int QUEUE_DEPTH = 4,
  localparam int INDEX_W = $clog2(LINES),
  localparam int TAG_W = $bits(cache_pkg::word_addr_t) -
                         $clog2(cache_pkg::WORDS_PER_LINE) - INDEX_W
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  cpu_req_valid,
  output logic                  cpu_req_ready,
  input  cache_pkg::word_addr_t cpu_req_addr,
  input  cache_pkg::word_t      cpu_req_data,
  input  cache_pkg::byte_mask_t cpu_req_mask,
  output logic                  cpu_resp_valid,
  output cache_pkg::word_t      cpu_resp_data,
  input  logic                  mem_resp_valid,
  input  mem_pkg::line_t        mem_resp_data,
  output logic [INDEX_W-1:0]    meta_rd_index,
  output logic                  meta_wr_en,
  output logic [INDEX_W-1:0]    meta_wr_index,
  output logic                  meta_wr_valid,
  output logic                  meta_wr_dirty,
  output logic [TAG_W-1:0]      meta_wr_tag,
  input  logic                  meta_rd_valid,
  input  logic                  meta_rd_dirty,
  input  logic [TAG_W-1:0]      meta_rd_tag,
  output logic [INDEX_W-1:0]    data_rd_index,
  input  mem_pkg::line_t        data_rd_line,
  output logic [INDEX_W-1:0]    data_wr_index,
  output logic                  data_fill_en,
  output mem_pkg::line_t        data_fill_line,
  output logic                  data_word_en,
  output cache_pkg::word_sel_t  data_word_sel,
  output cache_pkg::word_t      data_word_data,
  output cache_pkg::byte_mask_t data_word_mask,
  mem_req_if.producer           req
);
  import cache_pkg::*;
  import mem_pkg::*;

  localparam int WORD_W = $bits(word_t);
  localparam int CREDIT_W = $clog2(QUEUE_DEPTH + 1);

  ctrl_state_t         state_q;
  ctrl_state_t         state_d;
  word_addr_t          req_addr_q;
  word_t               req_data_q;
  byte_mask_t          req_mask_q;
  logic                lookup_armed_q;
  logic [CREDIT_W-1:0] credits_q;

  logic [TAG_W-1:0]    req_tag;
  logic [INDEX_W-1:0]  req_index;
  word_sel_t           req_word;
  logic                req_is_write;
  logic                lookup_done;
  logic                hit;
  line_t               merged_line;
  line_t               resp_line;

  function automatic word_t merge_word(word_t old_word, word_t new_word, byte_mask_t mask);
    word_t result;
    result = old_word;
    for (int b = 0; b < $bits(byte_mask_t); b++) begin
      if (mask[b]) begin
        result[b * 8 +: 8] = new_word[b * 8 +: 8];
      end
    end
    return result;
  endfunction

  assign {req_tag, req_index, req_word} = req_addr_q;
  assign req_is_write = |req_mask_q;

  // the arrays need one cycle after the request is latched before the tag is usable
  assign lookup_done = (state_q == ST_LOOKUP) && lookup_armed_q;
  assign hit = meta_rd_valid && (meta_rd_tag == req_tag);

  assign cpu_req_ready = (state_q == ST_IDLE);

  assign meta_rd_index = req_index;
  assign meta_wr_index = req_index;
  assign data_rd_index = req_index;
  assign data_wr_index = req_index;

  assign data_word_en   = lookup_done && hit && req_is_write;
  assign data_word_sel  = req_word;
  assign data_word_data = req_data_q;
  assign data_word_mask = req_mask_q;

  // a pending write is folded into the fetched line so the fill lands in one cycle
  always_comb begin
    merged_line = mem_resp_data;
    merged_line[int'(req_word) * WORD_W +: WORD_W] =
      merge_word(mem_resp_data[int'(req_word) * WORD_W +: WORD_W], req_data_q, req_mask_q);
  end

  assign data_fill_en   = (state_q == ST_FILL) && mem_resp_valid;
  assign data_fill_line = merged_line;

  assign meta_wr_en    = data_word_en || data_fill_en;
  assign meta_wr_valid = 1'b1;
  assign meta_wr_dirty = req_is_write;
  assign meta_wr_tag   = req_tag;

  // the victim tag and line stay on the array outputs until the fill
  assign req.valid = (credits_q != '0) &&
                     ((state_q == ST_WRITEBACK) || (state_q == ST_FETCH));
  assign req.write = (state_q == ST_WRITEBACK);
  assign req.addr  = (state_q == ST_WRITEBACK) ? {meta_rd_tag, req_index} :
                                                 {req_tag, req_index};
  assign req.data  = data_rd_line;

  assign resp_line = (state_q == ST_FILL) ? mem_resp_data : data_rd_line;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (cpu_req_valid) begin
          state_d = ST_LOOKUP;
        end
      end
      ST_LOOKUP: begin
        if (lookup_done) begin
          if (hit) begin
            state_d = ST_IDLE;
          end else if (meta_rd_valid && meta_rd_dirty) begin
            state_d = ST_WRITEBACK;
          end else begin
            state_d = ST_FETCH;
          end
        end
      end
      ST_WRITEBACK: begin
        if (req.valid) begin
          state_d = ST_FETCH;
        end
      end
      ST_FETCH: begin
        if (req.valid) begin
          state_d = ST_FILL;
        end
      end
      ST_FILL: begin
        if (mem_resp_valid) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q        <= ST_IDLE;
      lookup_armed_q <= 1'b0;
      credits_q      <= CREDIT_W'(QUEUE_DEPTH);
      cpu_resp_valid <= 1'b0;
    end else begin
      state_q        <= state_d;
      lookup_armed_q <= (state_q == ST_LOOKUP);
      cpu_resp_valid <= !req_is_write &&
                        ((lookup_done && hit) || data_fill_en);
      case ({req.credit, req.valid})
        2'b10: credits_q <= credits_q + 1'b1;
        2'b01: credits_q <= credits_q - 1'b1;
        default: credits_q <= credits_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cpu_req_valid && cpu_req_ready) begin
      req_addr_q <= cpu_req_addr;
      req_data_q <= cpu_req_data;
      req_mask_q <= cpu_req_mask;
    end
    cpu_resp_data <= resp_line[int'(req_word) * WORD_W +: WORD_W];
  end

endmodule

//--- hdl/mem_req_queue.sv
`timescale 1ns/10ps

module mem_req_queue #(
  parameter int QUEUE_DEPTH = 4,
  parameter int MEM_CREDITS = 2
) (
  input  logic                clk,
  input  logic                reset,
  mem_req_if.buffer           req,
  output logic                mem_req_valid,
  output logic                mem_req_write,
  output mem_pkg::line_addr_t mem_req_addr,
  output mem_pkg::line_t      mem_req_data,
  input  logic                mem_credit
);
  import mem_pkg::*;

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int COUNT_W = $clog2(QUEUE_DEPTH + 1);
  localparam int MCRED_W = $clog2(MEM_CREDITS + 1);

  logic               write_q [QUEUE_DEPTH];
  line_addr_t         addr_q [QUEUE_DEPTH];
  line_t              data_q [QUEUE_DEPTH];
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [COUNT_W-1:0] count_q;
  logic [MCRED_W-1:0] mem_credits_q;
  logic               issue;

  function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // the head leaves as soon as memory has room for it
  assign issue = (count_q != '0) && (mem_credits_q != '0);

  assign mem_req_valid = issue;
  assign mem_req_write = write_q[rd_ptr_q];
  assign mem_req_addr  = addr_q[rd_ptr_q];
  assign mem_req_data  = data_q[rd_ptr_q];
  assign req.credit    = issue;

  always_ff @(posedge clk) begin
    if (req.valid) begin
      write_q[wr_ptr_q] <= req.write;
      addr_q[wr_ptr_q]  <= req.addr;
      data_q[wr_ptr_q]  <= req.data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr_q      <= '0;
      rd_ptr_q      <= '0;
      count_q       <= '0;
      mem_credits_q <= MCRED_W'(MEM_CREDITS);
    end else begin
      if (req.valid) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (issue) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({req.valid, issue})
        2'b10: count_q <= count_q + 1'b1;
        2'b01: count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      case ({mem_credit, issue})
        2'b10: mem_credits_q <= mem_credits_q + 1'b1;
        2'b01: mem_credits_q <= mem_credits_q - 1'b1;
        default: mem_credits_q <= mem_credits_q;
      endcase
    end
  end

endmodule

//--- hdl/cache_top.sv
`timescale 1ns/10ps

module cache_top #(
  parameter int LINES = 64,
  parameter int QUEUE_DEPTH = 4,
  parameter int MEM_CREDITS = 2,
  localparam int INDEX_W = $clog2(LINES),
  localparam int TAG_W = $bits(cache_pkg::word_addr_t) -
                         $clog2(cache_pkg::WORDS_PER_LINE) - INDEX_W
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  cpu_req_valid,
  output logic                  cpu_req_ready,
  input  cache_pkg::word_addr_t cpu_req_addr,
  input  cache_pkg::word_t      cpu_req_data,
  input  cache_pkg::byte_mask_t cpu_req_mask,
  output logic                  cpu_resp_valid,
  output cache_pkg::word_t      cpu_resp_data,
  output logic                  mem_req_valid,
  output logic                  mem_req_write,
  output mem_pkg::line_addr_t   mem_req_addr,
  output mem_pkg::line_t        mem_req_data,
  input  logic                  mem_credit,
  input  logic                  mem_resp_valid,
  input  mem_pkg::line_t        mem_resp_data
);
  import cache_pkg::*;
  import mem_pkg::*;

  logic [INDEX_W-1:0] meta_rd_index;
  logic               meta_wr_en;
  logic [INDEX_W-1:0] meta_wr_index;
  logic               meta_wr_valid;
  logic               meta_wr_dirty;
  logic [TAG_W-1:0]   meta_wr_tag;
  logic               meta_rd_valid;
  logic               meta_rd_dirty;
  logic [TAG_W-1:0]   meta_rd_tag;
  logic [INDEX_W-1:0] data_rd_index;
  line_t              data_rd_line;
  logic [INDEX_W-1:0] data_wr_index;
  logic               data_fill_en;
  line_t              data_fill_line;
  logic               data_word_en;
  word_sel_t          data_word_sel;
  word_t              data_word_data;
  byte_mask_t         data_word_mask;

  mem_req_if req_bus ();

  cache_ctrl #(
    .LINES(LINES),
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) u_ctrl (
    .clk(clk),
    .reset(reset),
    .cpu_req_valid(cpu_req_valid),
    .cpu_req_ready(cpu_req_ready),
    .cpu_req_addr(cpu_req_addr),
    .cpu_req_data(cpu_req_data),
    .cpu_req_mask(cpu_req_mask),
    .cpu_resp_valid(cpu_resp_valid),
    .cpu_resp_data(cpu_resp_data),
    .mem_resp_valid(mem_resp_valid),
    .mem_resp_data(mem_resp_data),
    .meta_rd_index(meta_rd_index),
    .meta_wr_en(meta_wr_en),
    .meta_wr_index(meta_wr_index),
    .meta_wr_valid(meta_wr_valid),
    .meta_wr_dirty(meta_wr_dirty),
    .meta_wr_tag(meta_wr_tag),
    .meta_rd_valid(meta_rd_valid),
    .meta_rd_dirty(meta_rd_dirty),
    .meta_rd_tag(meta_rd_tag),
    .data_rd_index(data_rd_index),
    .data_rd_line(data_rd_line),
    .data_wr_index(data_wr_index),
    .data_fill_en(data_fill_en),
    .data_fill_line(data_fill_line),
    .data_word_en(data_word_en),
    .data_word_sel(data_word_sel),
    .data_word_data(data_word_data),
    .data_word_mask(data_word_mask),
    .req(req_bus.producer)
  );

  cache_meta #(
    .LINES(LINES)
  ) u_meta (
    .clk(clk),
    .reset(reset),
    .rd_index(meta_rd_index),
    .wr_en(meta_wr_en),
    .wr_index(meta_wr_index),
    .wr_valid(meta_wr_valid),
    .wr_dirty(meta_wr_dirty),
    .wr_tag(meta_wr_tag),
    .rd_valid(meta_rd_valid),
    .rd_dirty(meta_rd_dirty),
    .rd_tag(meta_rd_tag)
  );

  cache_data #(
    .LINES(LINES)
  ) u_data (
    .clk(clk),
    .rd_index(data_rd_index),
    .rd_line(data_rd_line),
    .wr_index(data_wr_index),
    .fill_en(data_fill_en),
    .fill_line(data_fill_line),
    .word_en(data_word_en),
    .word_sel(data_word_sel),
    .word_data(data_word_data),
    .word_mask(data_word_mask)
  );

  mem_req_queue #(
    .QUEUE_DEPTH(QUEUE_DEPTH),
    .MEM_CREDITS(MEM_CREDITS)
  ) u_queue (
    .clk(clk),
    .reset(reset),
    .req(req_bus.buffer),
    .mem_req_valid(mem_req_valid),
    .mem_req_write(mem_req_write),
    .mem_req_addr(mem_req_addr),
    .mem_req_data(mem_req_data),
    .mem_credit(mem_credit)
  );

endmodule

//--- tests/cache_tb.sv
`timescale 1ns/10ps

module cache_tb;
  import cache_pkg::*;
  import mem_pkg::*;

  localparam int LINES = 64;
  localparam int QUEUE_DEPTH = 4;
  localparam int MEM_CREDITS = 2;
  localparam int MEM_LINES = 1024;
  localparam int WAIT_LIMIT = 200;

  logic       clk;
  logic       reset;
  logic       cpu_req_valid;
  logic       cpu_req_ready;
  word_addr_t cpu_req_addr;
  word_t      cpu_req_data;
  byte_mask_t cpu_req_mask;
  logic       cpu_resp_valid;
  word_t      cpu_resp_data;
  logic       mem_req_valid;
  logic       mem_req_write;
  line_addr_t mem_req_addr;
  line_t      mem_req_data;
  logic       mem_credit;
  logic       mem_resp_valid;
  line_t      mem_resp_data;

  line_t      mem [MEM_LINES];
  int         credit_due [$];
  int         resp_due [$];
  line_t      resp_line [$];
  int         mem_credits;
  logic       hold_credits;
  int         max_delay;
  int         cycle;

  // requests that memory has taken in the order it took them
  logic       log_write [$];
  line_addr_t log_addr [$];
  line_t      log_data [$];

  // the initial pattern still holds for every word the CPU has not written
  word_t      shadow [int];

  integer     seed;
  string      test_name;
  int         test_errors;
  int         tests_passed;
  int         tests_failed;
  logic       timed_out;
  int         latency;
  word_t      read_data;

  cache_top #(
    .LINES(LINES),
    .QUEUE_DEPTH(QUEUE_DEPTH),
    .MEM_CREDITS(MEM_CREDITS)
  ) dut (
    .clk(clk),
    .reset(reset),
    .cpu_req_valid(cpu_req_valid),
    .cpu_req_ready(cpu_req_ready),
    .cpu_req_addr(cpu_req_addr),
    .cpu_req_data(cpu_req_data),
    .cpu_req_mask(cpu_req_mask),
    .cpu_resp_valid(cpu_resp_valid),
    .cpu_resp_data(cpu_resp_data),
    .mem_req_valid(mem_req_valid),
    .mem_req_write(mem_req_write),
    .mem_req_addr(mem_req_addr),
    .mem_req_data(mem_req_data),
    .mem_credit(mem_credit),
    .mem_resp_valid(mem_resp_valid),
    .mem_resp_data(mem_resp_data)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic int rand_below(int n);
    int r;
    r = $random(seed);
    return (r & 32'h7fffffff) % n;
  endfunction

  // line address times four plus the word index is just the word address
  function automatic word_t expected_word(int addr);
    if (shadow.exists(addr)) begin
      return shadow[addr];
    end
    return word_t'(addr);
  endfunction

  function automatic line_t expected_line(int line_addr);
    line_t l;
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      l[w * 32 +: 32] = expected_word(line_addr * WORDS_PER_LINE + w);
    end
    return l;
  endfunction

  function automatic word_t apply_mask(word_t old_word, word_t new_word, byte_mask_t mask);
    word_t bits;
    bits = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
    return (old_word & ~bits) | (new_word & bits);
  endfunction

  task automatic check_value(string what, logic [127:0] expected, logic [127:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic report_and_finish();
    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  endtask

  task automatic note_timeout(string why);
    $display("%s during test %s", why, test_name);
    test_errors++;
    timed_out = 1'b1;
  endtask

  task automatic start_test(string name);
    test_name = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    if (test_errors == 0) begin
      tests_passed++;
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", test_name, test_errors);
    end
  endtask

  // the memory model samples and drives on the falling edge
  initial begin
    mem_credit = 1'b0;
    mem_resp_valid = 1'b0;
    mem_resp_data = '0;
    cycle = 0;
    mem_credits = MEM_CREDITS;
    for (int l = 0; l < MEM_LINES; l++) begin
      for (int w = 0; w < WORDS_PER_LINE; w++) begin
        mem[l][w * 32 +: 32] = word_t'(l * WORDS_PER_LINE + w);
      end
    end
    forever begin
      @(negedge clk);
      cycle++;
      mem_credit = 1'b0;
      mem_resp_valid = 1'b0;
      if (mem_req_valid) begin
        check_value("memory credit at issue", 128'(1), 128'(mem_credits > 0));
        mem_credits--;
        credit_due.push_back(cycle + 1 + rand_below(max_delay));
        log_write.push_back(mem_req_write);
        log_addr.push_back(mem_req_addr);
        log_data.push_back(mem_req_data);
        if (mem_req_write) begin
          mem[mem_req_addr[9:0]] = mem_req_data;
        end else begin
          resp_due.push_back(cycle + 1 + rand_below(max_delay));
          resp_line.push_back(mem[mem_req_addr[9:0]]);
        end
      end
      if (!hold_credits && credit_due.size() > 0 && credit_due[0] <= cycle) begin
        mem_credit = 1'b1;
        mem_credits++;
        credit_due.delete(0);
      end
      // lines leave strictly in request order
      if (resp_due.size() > 0 && resp_due[0] <= cycle) begin
        mem_resp_valid = 1'b1;
        mem_resp_data = resp_line[0];
        resp_due.delete(0);
        resp_line.delete(0);
      end
    end
  end

  task automatic wait_ready();
    int t;
    t = 0;
    while (!cpu_req_ready && !timed_out) begin
      if (t == WAIT_LIMIT) begin
        note_timeout("timeout: cpu_req_ready stayed low");
      end else begin
        t++;
        @(negedge clk);
      end
    end
    latency = t;
  endtask

  task automatic wait_response();
    int t;
    t = 0;
    while (!cpu_resp_valid && !timed_out) begin
      if (t == WAIT_LIMIT) begin
        note_timeout("timeout: no read response from the cache");
      end else begin
        t++;
        @(negedge clk);
      end
    end
    latency = t;
    read_data = cpu_resp_data;
  endtask

  task automatic wait_credits_home();
    int t;
    t = 0;
    while (mem_credits != MEM_CREDITS && !timed_out) begin
      if (t == WAIT_LIMIT) begin
        note_timeout("timeout: memory credits never came back");
      end else begin
        t++;
        @(negedge clk);
      end
    end
  endtask

  task automatic send_request(int addr, word_t data, byte_mask_t mask);
    wait_ready();
    cpu_req_valid = 1'b1;
    cpu_req_addr = word_addr_t'(addr);
    cpu_req_data = data;
    cpu_req_mask = mask;
    @(negedge clk);
    cpu_req_valid = 1'b0;
  endtask

  task automatic do_read(int addr);
    send_request(addr, '0, '0);
    wait_response();
    check_value("read data", 128'(expected_word(addr)), 128'(read_data));
  endtask

  task automatic do_write(int addr, word_t data, byte_mask_t mask);
    send_request(addr, data, mask);
    wait_ready();
    shadow[addr] = apply_mask(expected_word(addr), data, mask);
  endtask

  task automatic write_and_read_back(int addr, word_t data, byte_mask_t mask);
    do_write(addr, data, mask);
    check_value("write hit latency", 128'(2), 128'(latency));
    do_read(addr);
    check_value("read hit latency", 128'(2), 128'(latency));
  endtask

  task automatic test_reset();
    start_test("reset");
    check_value("cpu_req_ready", 128'(1), 128'(cpu_req_ready));
    check_value("cpu_resp_valid", 128'(0), 128'(cpu_resp_valid));
    check_value("mem_req_valid", 128'(0), 128'(mem_req_valid));
    finish_test();
  endtask

  task automatic test_miss_then_hit();
    int mark;
    start_test("miss_then_hit");
    mark = log_addr.size();
    do_read(41);
    check_value("fetch count", 128'(1), 128'(log_addr.size() - mark));
    if (log_addr.size() == mark + 1) begin
      check_value("fetch is a read", 128'(0), 128'(log_write[mark]));
      check_value("fetch address", 128'(10), 128'(log_addr[mark]));
    end
    do_read(42);
    check_value("hit latency", 128'(2), 128'(latency));
    check_value("requests on hit", 128'(1), 128'(log_addr.size() - mark));
    finish_test();
  endtask

  task automatic test_byte_writes();
    start_test("byte_writes");
    do_read(80);
    write_and_read_back(81, 32'haabbccdd, 4'b0001);
    write_and_read_back(81, 32'h11223344, 4'b0110);
    write_and_read_back(81, 32'hcafef00d, 4'b1111);
    finish_test();
  endtask

  // lines 69 and 133 share index 5
  task automatic test_dirty_eviction();
    int mark;
    start_test("dirty_eviction");
    do_write(279, 32'h12345678, 4'b1111);
    mark = log_addr.size();
    do_read(533);
    check_value("requests on eviction", 128'(2), 128'(log_addr.size() - mark));
    if (log_addr.size() == mark + 2) begin
      check_value("writeback first", 128'(1), 128'(log_write[mark]));
      check_value("writeback address", 128'(69), 128'(log_addr[mark]));
      check_value("writeback line", expected_line(69), log_data[mark]);
      check_value("fetch second", 128'(0), 128'(log_write[mark + 1]));
      check_value("fetch address", 128'(133), 128'(log_addr[mark + 1]));
    end
    do_read(279);
    finish_test();
  endtask

  task automatic test_credit_stall();
    int mark;
    start_test("credit_stall");
    wait_credits_home();
    hold_credits = 1'b1;
    do_read(120);
    do_read(124);
    check_value("credits drained", 128'(0), 128'(mem_credits));
    mark = log_addr.size();
    send_request(128, '0, '0);
    for (int i = 0; i < 50; i++) begin
      check_value("request while stalled", 128'(0), 128'(mem_req_valid));
      check_value("response while stalled", 128'(0), 128'(cpu_resp_valid));
      @(negedge clk);
    end
    check_value("requests while stalled", 128'(0), 128'(log_addr.size() - mark));
    hold_credits = 1'b0;
    wait_response();
    check_value("read data", 128'(expected_word(128)), 128'(read_data));
    check_value("requests after stall", 128'(1), 128'(log_addr.size() - mark));
    finish_test();
  endtask

  // 16 lines spread over indexes 40 to 42
  task automatic test_random_mix();
    int k;
    int addr;
    start_test("random_mix");
    max_delay = 8;
    for (int i = 0; i < 200; i++) begin
      k = rand_below(16);
      addr = ((k / 3) * LINES + 40 + k % 3) * WORDS_PER_LINE + rand_below(4);
      if (rand_below(2) == 1) begin
        do_write(addr, word_t'($random(seed)), byte_mask_t'(1 + rand_below(15)));
      end else begin
        do_read(addr);
      end
    end
    finish_test();
  endtask

  initial begin
    seed = 58;
    hold_credits = 1'b0;
    max_delay = 4;
    tests_passed = 0;
    tests_failed = 0;
    test_errors = 0;
    timed_out = 1'b0;
    test_name = "reset";
    reset = 1'b1;
    cpu_req_valid = 1'b0;
    cpu_req_addr = '0;
    cpu_req_data = '0;
    cpu_req_mask = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    test_reset();
    if (!timed_out) begin
      test_miss_then_hit();
    end
    if (!timed_out) begin
      test_byte_writes();
    end
    if (!timed_out) begin
      test_dirty_eviction();
    end
    if (!timed_out) begin
      test_credit_stall();
    end
    if (!timed_out) begin
      test_random_mix();
    end
    report_and_finish();
  end

endmodule

//--- list.f
hdl/cache_pkg.sv
hdl/mem_pkg.sv
hdl/mem_req_if.sv
hdl/cache_meta.sv
hdl/cache_data.sv
hdl/cache_ctrl.sv
hdl/mem_req_queue.sv
hdl/cache_top.sv
tests/cache_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps --top-module cache_tb -f list.f -o cache_sim

output="$(./obj_dir/cache_sim)"
echo "$output"

if grep -qx "Finished with no errors" <<< "$output"; then
  exit 0
else
  exit 1
fi
